// File: logic/isa_pkg.sv
package isa_pkg;

	typedef logic [31:0] word_t;     // Data word, register value or instruction
	typedef logic [4:0]  reg_idx_t;  // Index zero reads 0 and drops writes
	typedef logic [15:0] imm_t;      // Sign-extended in decode

	// Anything outside this list decodes as a bubble
	typedef enum logic [5:0] {
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLT  = 6'h06,
		OP_ADDI = 6'h08,
		OP_SW   = 6'h2b,
		OP_SWX  = 6'h2c  // Indexed store, address rs+rd
	} opcode_t;

	// Instruction word fields
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 26;
	localparam int RS_HI  = 25;
	localparam int RS_LO  = 21;
	localparam int RT_HI  = 20;
	localparam int RT_LO  = 16;
	localparam int RD_HI  = 15;
	localparam int RD_LO  = 11;
	localparam int IMM_HI = 15;  // Overlaps rd
	localparam int IMM_LO = 0;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

	// Operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_NONE = 2'b00,  // ID/EX copy
		FWD_WB   = 2'b01,  // MEM/WB result
		FWD_MEM  = 2'b10   // EX/MEM result
	} fwd_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT  // Signed compare, yields 1 or 0
	} alu_fn_t;

endpackage

// File: logic/stage_if.sv
`timescale 1ns/10ps

// Destination and result of one pipeline stage
interface stage_result_if import isa_pkg::*; ();
	logic     valid;
	logic     reg_write;  // Meaningful only with valid
	reg_idx_t rd;
	word_t    value;      // ALU result, the address for stores
	logic     is_store;

	modport producer (output valid, reg_write, rd, value, is_store);
	modport consumer (input valid, reg_write, rd, value, is_store);
endinterface

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file import isa_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t rs,
	input  reg_idx_t rt,
	input  reg_idx_t rd,
	output word_t    rs_value,
	output word_t    rt_value,
	output word_t    rd_value,
	stage_result_if.consumer wr
);
	word_t regs [1:31];
	logic wr_en;

	assign wr_en = wr.valid && wr.reg_write && (wr.rd != '0);

	// Write-first, so a reader three behind the producer sees the new value
	function automatic word_t read_port(reg_idx_t idx);
		if (idx == '0)
			return '0;
		if (wr_en && wr.rd == idx)
			return wr.value;
		return regs[idx];
	endfunction

	always_comb begin
		rs_value = read_port(rs);
		rt_value = read_port(rt);
		rd_value = read_port(rd);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr.rd] <= wr.value;
		end
	end

endmodule

// File: logic/forward_unit.sv
`timescale 1ns/10ps

module forward_unit import isa_pkg::*, pipe_pkg::*; (
	input  reg_idx_t ex_rs,
	input  reg_idx_t ex_b_idx,     // rt, or rd for SWX
	input  reg_idx_t ex_rt,
	input  logic     ex_b_is_reg,
	input  logic     ex_store,
	stage_result_if.consumer exmem,
	stage_result_if.consumer memwb,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b,
	output fwd_sel_t fwd_c
);
	logic mem_wr, wb_wr;

	// r0 never forwards
	assign mem_wr = exmem.valid && exmem.reg_write && (exmem.rd != '0);
	assign wb_wr = memwb.valid && memwb.reg_write && (memwb.rd != '0);

	// Younger producer in EX/MEM wins over MEM/WB
	function automatic fwd_sel_t source_of(reg_idx_t idx, logic mem_en, reg_idx_t mem_rd,
			logic wb_en, reg_idx_t wb_rd);
		if (mem_en && mem_rd == idx)
			return FWD_MEM;
		if (wb_en && wb_rd == idx)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = source_of(ex_rs, mem_wr, exmem.rd, wb_wr, memwb.rd);
		fwd_b = FWD_NONE;
		fwd_c = FWD_NONE;
		if (ex_b_is_reg)
			fwd_b = source_of(ex_b_idx, mem_wr, exmem.rd, wb_wr, memwb.rd);
		if (ex_store)  // Store data only
			fwd_c = source_of(ex_rt, mem_wr, exmem.rd, wb_wr, memwb.rd);
	end

endmodule

// File: logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     instr_valid,
	input  word_t    instr,
	stage_result_if.consumer wb,
	output reg_idx_t ex_rs,
	output reg_idx_t ex_rt,
	output reg_idx_t ex_rd,       // Destination, or the index register of SWX
	output word_t    ex_a,
	output word_t    ex_b_reg,
	output word_t    ex_c,        // Store data
	output word_t    ex_imm,
	output alu_fn_t  ex_fn,
	output logic     ex_valid,
	output logic     ex_use_imm,
	output logic     ex_b_from_rd,
	output logic     ex_reg_write,
	output logic     ex_store
);
	opcode_t  opc;
	reg_idx_t rs, rt, rd, dest;
	imm_t     imm;
	word_t    rs_value, rt_value, rd_value;
	alu_fn_t  fn;
	logic     known, use_imm, b_from_rd, reg_write, store;

	assign opc = opcode_t'(instr[OPC_HI:OPC_LO]);
	assign rs = instr[RS_HI:RS_LO];
	assign rt = instr[RT_HI:RT_LO];
	assign rd = instr[RD_HI:RD_LO];
	assign imm = instr[IMM_HI:IMM_LO];
	assign dest = (opc == OP_ADDI) ? rt : rd;  // ADDI writes rt

	reg_file rf_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs       (rs),
		.rt       (rt),
		.rd       (rd),
		.rs_value (rs_value),
		.rt_value (rt_value),
		.rd_value (rd_value),
		.wr       (wb)
	);

	always_comb begin
		known = 1'b1;
		fn = ALU_ADD;
		use_imm = 1'b0;
		b_from_rd = 1'b0;
		store = 1'b0;
		case (opc)
			OP_ADD:  fn = ALU_ADD;
			OP_SUB:  fn = ALU_SUB;
			OP_AND:  fn = ALU_AND;
			OP_OR:   fn = ALU_OR;
			OP_XOR:  fn = ALU_XOR;
			OP_SLT:  fn = ALU_SLT;
			OP_ADDI: use_imm = 1'b1;
			OP_SW: begin
				use_imm = 1'b1;  // rs+imm
				store = 1'b1;
			end
			OP_SWX: begin
				b_from_rd = 1'b1;  // rs+rd
				store = 1'b1;
			end
			default: known = 1'b0;
		endcase
		reg_write = known && !store;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_valid <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_store <= 1'b0;
		end else begin
			ex_valid <= instr_valid && known;
			ex_reg_write <= instr_valid && reg_write;
			ex_store <= instr_valid && store;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs <= rs;
		ex_rt <= rt;
		ex_rd <= dest;
		ex_a <= rs_value;
		ex_b_reg <= b_from_rd ? rd_value : rt_value;
		ex_c <= rt_value;
		ex_imm <= {{16{imm[15]}}, imm};
		ex_fn <= fn;
		ex_use_imm <= use_imm;
		ex_b_from_rd <= b_from_rd;
	end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import isa_pkg::*, pipe_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  reg_idx_t ex_rs,
	input  reg_idx_t ex_rt,
	input  reg_idx_t ex_rd,
	input  word_t    ex_a,
	input  word_t    ex_b_reg,
	input  word_t    ex_c,
	input  word_t    ex_imm,
	input  alu_fn_t  ex_fn,
	input  logic     ex_valid,
	input  logic     ex_use_imm,
	input  logic     ex_b_from_rd,
	input  logic     ex_reg_write,
	input  logic     ex_store,
	stage_result_if.producer exmem,
	stage_result_if.consumer memwb,
	output word_t    st_value
);
	stage_result_if ex_mem_q ();  // EX/MEM register, also seen by the forwarding logic

	reg_idx_t b_idx;
	fwd_sel_t fwd_a, fwd_b, fwd_c;
	word_t    op_a, op_b_reg, op_b, op_c, alu_y;

	function automatic word_t pick(fwd_sel_t sel, word_t own, word_t mem_v, word_t wb_v);
		case (sel)
			FWD_MEM: return mem_v;
			FWD_WB:  return wb_v;
			default: return own;
		endcase
	endfunction

	assign b_idx = ex_b_from_rd ? ex_rd : ex_rt;

	forward_unit fwd_i (
		.ex_rs       (ex_rs),
		.ex_b_idx    (b_idx),
		.ex_rt       (ex_rt),
		.ex_b_is_reg (!ex_use_imm),
		.ex_store    (ex_store),
		.exmem       (ex_mem_q),
		.memwb       (memwb),
		.fwd_a       (fwd_a),
		.fwd_b       (fwd_b),
		.fwd_c       (fwd_c)
	);

	assign op_a = pick(fwd_a, ex_a, ex_mem_q.value, memwb.value);
	assign op_b_reg = pick(fwd_b, ex_b_reg, ex_mem_q.value, memwb.value);
	assign op_c = pick(fwd_c, ex_c, ex_mem_q.value, memwb.value);
	assign op_b = ex_use_imm ? ex_imm : op_b_reg;

	always_comb begin
		case (ex_fn)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_XOR: alu_y = op_a ^ op_b;
			ALU_SLT: alu_y = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			default: alu_y = op_a + op_b;  // Also store address
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_q.valid <= 1'b0;
			ex_mem_q.reg_write <= 1'b0;
			ex_mem_q.is_store <= 1'b0;
		end else begin
			ex_mem_q.valid <= ex_valid;
			ex_mem_q.reg_write <= ex_reg_write;
			ex_mem_q.is_store <= ex_store;
		end
	end

	always_ff @(posedge clk) begin
		ex_mem_q.rd <= ex_rd;
		ex_mem_q.value <= alu_y;
		st_value <= op_c;
	end

	assign exmem.valid = ex_mem_q.valid;
	assign exmem.reg_write = ex_mem_q.reg_write;
	assign exmem.rd = ex_mem_q.rd;
	assign exmem.value = ex_mem_q.value;
	assign exmem.is_store = ex_mem_q.is_store;

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/10ps

module mem_stage import isa_pkg::*; (
	input  logic  clk,
	input  logic  arst_n,
	stage_result_if.consumer exmem,
	input  word_t ex_st_value,
	stage_result_if.producer memwb,
	output logic  st_valid,
	output word_t st_addr,
	output word_t st_data
);
	// Store port straight from EX/MEM
	assign st_valid = exmem.valid && exmem.is_store;
	assign st_addr = exmem.value;
	assign st_data = ex_st_value;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			memwb.valid <= 1'b0;
			memwb.reg_write <= 1'b0;
			memwb.is_store <= 1'b0;
		end else begin
			memwb.valid <= exmem.valid;
			memwb.reg_write <= exmem.reg_write && !exmem.is_store;  // Stores write nothing
			memwb.is_store <= exmem.is_store;
		end
	end

	always_ff @(posedge clk) begin
		memwb.rd <= exmem.rd;
		memwb.value <= exmem.value;
	end

endmodule

// File: logic/exec_core.sv
`timescale 1ns/10ps

module exec_core import isa_pkg::*, pipe_pkg::*; (
	input  logic     clk,
	input  logic     arst_n,
	input  logic     instr_valid,
	input  word_t    instr,
	output logic     wb_valid,
	output reg_idx_t wb_rd,
	output word_t    wb_value,
	output logic     st_valid,
	output word_t    st_addr,
	output word_t    st_data
);
	stage_result_if exmem_bus ();
	stage_result_if memwb_bus ();

	// ID/EX
	reg_idx_t ex_rs, ex_rt, ex_rd;
	word_t    ex_a, ex_b_reg, ex_c, ex_imm;
	alu_fn_t  ex_fn;
	logic     ex_valid, ex_use_imm, ex_b_from_rd, ex_reg_write, ex_store;

	word_t    ex_st_value;

	decode_stage dec_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.wb           (memwb_bus),
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.ex_rd        (ex_rd),
		.ex_a         (ex_a),
		.ex_b_reg     (ex_b_reg),
		.ex_c         (ex_c),
		.ex_imm       (ex_imm),
		.ex_fn        (ex_fn),
		.ex_valid     (ex_valid),
		.ex_use_imm   (ex_use_imm),
		.ex_b_from_rd (ex_b_from_rd),
		.ex_reg_write (ex_reg_write),
		.ex_store     (ex_store)
	);

	execute_stage exe_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.ex_rs        (ex_rs),
		.ex_rt        (ex_rt),
		.ex_rd        (ex_rd),
		.ex_a         (ex_a),
		.ex_b_reg     (ex_b_reg),
		.ex_c         (ex_c),
		.ex_imm       (ex_imm),
		.ex_fn        (ex_fn),
		.ex_valid     (ex_valid),
		.ex_use_imm   (ex_use_imm),
		.ex_b_from_rd (ex_b_from_rd),
		.ex_reg_write (ex_reg_write),
		.ex_store     (ex_store),
		.exmem        (exmem_bus),
		.memwb        (memwb_bus),
		.st_value     (ex_st_value)
	);

	mem_stage mem_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.exmem       (exmem_bus),
		.ex_st_value (ex_st_value),
		.memwb       (memwb_bus),
		.st_valid    (st_valid),
		.st_addr     (st_addr),
		.st_data     (st_data)
	);

	// Trace shows real register writes only
	assign wb_valid = memwb_bus.valid && memwb_bus.reg_write && (memwb_bus.rd != '0);
	assign wb_rd = memwb_bus.rd;
	assign wb_value = memwb_bus.value;

endmodule

// File: tests/exec_core_asserts.sv
`timescale 1ns/10ps

module exec_core_asserts import isa_pkg::*; (
	input logic     clk,
	input logic     arst_n,
	input logic     wb_valid,
	input reg_idx_t wb_rd,
	input logic     st_valid
);
	// The store reaches MEM/WB one cycle after its store beat
	store_not_traced: assert property (@(posedge clk) disable iff (!arst_n)
		st_valid |=> !wb_valid)
		else $error("Store instruction also produced a write-back beat");

	trace_rd_nonzero: assert property (@(posedge clk) disable iff (!arst_n)
		wb_valid |-> wb_rd != 5'd0)
		else $error("Write-back beat for r0");

	valid_known: assert property (@(posedge clk) disable iff (!arst_n)
		!$isunknown({wb_valid, st_valid}))
		else $error("Unknown value on wb_valid or st_valid");

endmodule

bind exec_core exec_core_asserts asserts_i (
	.clk      (clk),
	.arst_n   (arst_n),
	.wb_valid (wb_valid),
	.wb_rd    (wb_rd),
	.st_valid (st_valid)
);

// File: tests/exec_core_tb.sv
`timescale 1ns/10ps

module exec_core_tb import isa_pkg::*; ();
	logic     clk;
	logic     arst_n;
	logic     instr_valid;
	word_t    instr;
	logic     wb_valid;
	reg_idx_t wb_rd;
	word_t    wb_value;
	logic     st_valid;
	word_t    st_addr;
	word_t    st_data;

	word_t       model_regs [32];
	logic [36:0] wb_q [$];  // {rd, value}
	logic [63:0] st_q [$];  // {addr, data}
	int          errors = 0;
	int          errors_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	opcode_t    alu_ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
	logic [5:0] bad_ops [4] = '{6'h00, 6'h07, 6'h10, 6'h3f};

	exec_core dut_i (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_value    (wb_value),
		.st_valid    (st_valid),
		.st_addr     (st_addr),
		.st_data     (st_data)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_eq(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	function automatic word_t r_type(opcode_t op, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
		return {op, rs, rt, rd, 11'd0};
	endfunction

	function automatic word_t i_type(opcode_t op, reg_idx_t rt, reg_idx_t rs, imm_t imm);
		return {op, rs, rt, imm};
	endfunction

	// Architectural reference, one instruction at a time in program order
	function automatic void model_exec(word_t w);
		logic [5:0] opc;
		reg_idx_t   rs, rt, rd, dest;
		word_t      a, b, imm, y;
		logic       writes;
		opc = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		rd = w[15:11];
		a = model_regs[rs];
		b = model_regs[rt];
		imm = {{16{w[15]}}, w[15:0]};
		y = '0;
		writes = 1'b1;
		dest = rd;
		case (opc)
			OP_ADD: y = a + b;
			OP_SUB: y = a - b;
			OP_AND: y = a & b;
			OP_OR:  y = a | b;
			OP_XOR: y = a ^ b;
			OP_SLT: y = {31'd0, $signed(a) < $signed(b)};
			OP_ADDI: begin
				y = a + imm;
				dest = rt;
			end
			OP_SW: begin
				st_q.push_back({a + imm, b});
				writes = 1'b0;
			end
			OP_SWX: begin
				st_q.push_back({a + model_regs[rd], b});
				writes = 1'b0;
			end
			default: writes = 1'b0;  // Bubble
		endcase
		if (writes && dest != 5'd0) begin
			model_regs[dest] = y;
			wb_q.push_back({dest, y});
		end
	endfunction

	task automatic issue(input word_t w);
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr = w;
		model_exec(w);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
			instr = $urandom;  // Garbage that must be ignored
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		logic [36:0] wb_exp;
		logic [63:0] st_exp;
		if (wb_valid === 1'b1) begin
			if (wb_q.size() == 0) begin
				$display("Unexpected write-back of r%0d with value %h", wb_rd, wb_value);
				errors++;
			end else begin
				wb_exp = wb_q.pop_front();
				check_eq("wb_rd", 32'(wb_rd), 32'(wb_exp[36:32]));
				check_eq("wb_value", wb_value, wb_exp[31:0]);
			end
		end
		if (st_valid === 1'b1) begin
			if (st_q.size() == 0) begin
				$display("Unexpected store to %h with data %h", st_addr, st_data);
				errors++;
			end else begin
				st_exp = st_q.pop_front();
				check_eq("st_addr", st_addr, st_exp[63:32]);
				check_eq("st_data", st_data, st_exp[31:0]);
			end
		end
	end

	task automatic finish_test(input string name);
		int waited;
		idle(1);
		waited = 0;
		while ((wb_q.size() != 0 || st_q.size() != 0) && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (wb_q.size() != 0 || st_q.size() != 0) begin
			$display("Test %s: %0d write-back and %0d store beats never appeared",
				name, wb_q.size(), st_q.size());
			errors++;
			wb_q.delete();
			st_q.delete();
		end
		idle(3);  // Room for stray beats
		tests_run++;
		if (errors != errors_at_start) begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - errors_at_start);
		end else begin
			$display("Test %s: passed", name);
		end
		errors_at_start = errors;
	endtask

	initial begin
		reg_idx_t    a, b, c;
		int unsigned pick;
		void'($urandom(88));
		arst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;

		repeat (8) begin
			@(negedge clk);
			check_eq("wb_valid", 32'(wb_valid), 32'd0);
			check_eq("st_valid", 32'(st_valid), 32'd0);
		end
		@(posedge clk);
		#1;
		arst_n = 1'b1;
		idle(4);
		for (int x = 1; x < 32; x++)
			issue(r_type(OP_ADD, reg_idx_t'(x), reg_idx_t'(x), 5'd0));
		finish_test("reset");

		for (int i = 0; i < 60; i++) begin
			a = reg_idx_t'($urandom_range(3, 1));
			b = reg_idx_t'($urandom_range(3, 1));
			c = reg_idx_t'($urandom_range(3, 1));
			issue(i_type(OP_ADDI, a, b, imm_t'($urandom)));
			if (i % 2 == 1)
				issue(i_type(OP_ADDI, 5'd20, 5'd21, 16'h0011));  // Unrelated
			if (i % 4 < 2)
				issue(r_type(alu_ops[$urandom_range(5)], c, a, b));
			else
				issue(r_type(alu_ops[$urandom_range(5)], c, b, a));
		end
		finish_test("forward_one_two");

		for (int i = 0; i < 30; i++) begin
			a = reg_idx_t'($urandom_range(7, 1));
			issue(i_type(OP_ADDI, a, a, imm_t'($urandom)));
			issue(i_type(OP_ADDI, 5'd20, 5'd20, 16'h0001));
			issue(i_type(OP_ADDI, 5'd21, 5'd21, 16'h0002));
			issue(r_type(OP_ADD, 5'd9, a, a));
			issue(i_type(OP_ADDI, 5'd0, a, imm_t'($urandom)));  // Never traced
			issue(r_type(OP_OR, 5'd10, 5'd0, a));
		end
		finish_test("bypass_and_r0");

		for (int i = 0; i < 40; i++) begin
			a = reg_idx_t'($urandom_range(7, 1));
			b = reg_idx_t'($urandom_range(7, 1));
			c = reg_idx_t'($urandom_range(7, 1));
			issue(i_type(OP_ADDI, a, 5'd0, imm_t'($urandom)));
			issue(i_type(OP_ADDI, b, 5'd0, imm_t'($urandom)));
			issue(i_type(OP_ADDI, c, 5'd0, imm_t'($urandom)));
			if (i % 2 == 0)
				issue(i_type(OP_SW, c, b, imm_t'($urandom)));
			else
				issue(r_type(OP_SWX, c, a, b));
		end
		finish_test("store_forward");

		for (int i = 0; i < 2000; i++) begin
			pick = $urandom_range(99);
			a = reg_idx_t'($urandom_range(7));
			b = reg_idx_t'($urandom_range(7));
			c = reg_idx_t'($urandom_range(7));
			if (pick < 8)
				idle(1);
			else if (pick < 13)
				issue({bad_ops[$urandom_range(3)], a, b, c, 11'($urandom)});
			else if (pick < 25)
				issue(i_type(OP_ADDI, b, a, imm_t'($urandom)));
			else if (pick < 33)
				issue(i_type(OP_SW, b, a, imm_t'($urandom)));
			else if (pick < 41)
				issue(r_type(OP_SWX, c, a, b));
			else
				issue(r_type(alu_ops[$urandom_range(5)], c, a, b));
		end
		finish_test("random_mix");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_if.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/exec_core.sv
tests/exec_core_asserts.sv
tests/exec_core_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := exec_core_tb
FILELIST   := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := CHECKS FAILED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
